//--- logic/sm_cfg_pkg.sv
`default_nettype none

package sm_cfg_pkg;

  // bus and pin widths, all fixed by the SelectMAP x8 pinout
  localparam int unsigned SM_ADDR_W  = 2;
  localparam int unsigned SM_BYTE_W  = 8;
  localparam int unsigned SM_COUNT_W = 16;
  localparam int unsigned SM_MODE_W  = 3;

  typedef logic [SM_ADDR_W-1:0]  sm_addr_t;
  typedef logic [SM_BYTE_W-1:0]  sm_byte_t;
  typedef logic [SM_COUNT_W-1:0] sm_count_t;
  typedef logic [SM_MODE_W-1:0]  sm_mode_t;

  // register map
  localparam sm_addr_t REG_SM_STATUS = 2'd0;
  localparam sm_addr_t REG_SM_OREGS  = 2'd1;
  localparam sm_addr_t REG_SM_DATA   = 2'd2;
  localparam sm_addr_t REG_SM_CTRL   = 2'd3;

  // M[2:0] strapping for slave SelectMAP
  localparam sm_mode_t SM_MODE_SLAVE_SELECTMAP = 3'b110;

  // STATUS fields
  localparam int unsigned STATUS_INIT_N  = 0;
  localparam int unsigned STATUS_DONE    = 1;
  localparam int unsigned STATUS_BUSY    = 2;
  localparam int unsigned STATUS_SM_BUSY = 3;
  localparam int unsigned STATUS_CRC_ERR = 4;

  // OREGS fields
  localparam int unsigned OREGS_PROG_N   = 0;
  localparam int unsigned OREGS_INIT_N_O = 1;
  localparam int unsigned OREGS_RDWR_N   = 2;

  // CTRL fields, crc_clr is write-only
  localparam int unsigned CTRL_INIT_N_OEN = 0;
  localparam int unsigned CTRL_CRC_CLR    = 1;

endpackage

`default_nettype wire

//--- logic/sm_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sm_ctrl_regs
  import sm_cfg_pkg::*;
(
  input  wire      epb_clk,
  input  wire      wb_rst_i,
  input  wire      wb_cyc_i,
  input  wire      wb_stb_i,
  input  wire      wb_we_i,
  input  sm_addr_t wb_adr_i,
  input  sm_byte_t wb_dat_i,
  output sm_byte_t wb_dat_o,
  output logic     wb_ack_o,
  input  wire      sm_busy_i,
  input  wire      sync_init_n_i,
  input  wire      sync_done_i,
  input  wire      sync_busy_i,
  input  wire      crc_err_i,
  input  sm_byte_t count_byte_i,
  output logic     prog_n_o,
  output logic     rdwr_n_o,
  output logic     init_n_o,
  output logic     init_n_oen_o,
  output logic     crc_clr_o,
  output logic     prog_n_wr_o
);

  logic wb_trans;
  logic wr_en;
  sm_byte_t status_word;
  sm_byte_t oregs_word;
  sm_byte_t ctrl_word;

  // a transfer is taken once; the ack cycle itself is ignored
  assign wb_trans = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en    = wb_trans & wb_we_i;

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_trans;
    end
  end

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      prog_n_o     <= 1'b1;
      rdwr_n_o     <= 1'b0;
      init_n_o     <= 1'b1;
      init_n_oen_o <= 1'b1;
    end else if (wr_en) begin
      case (wb_adr_i)
        REG_SM_OREGS: begin
          prog_n_o <= wb_dat_i[OREGS_PROG_N];
          init_n_o <= wb_dat_i[OREGS_INIT_N_O];
          rdwr_n_o <= wb_dat_i[OREGS_RDWR_N];
        end
        REG_SM_CTRL: begin
          init_n_oen_o <= wb_dat_i[CTRL_INIT_N_OEN];
        end
        default: begin
        end
      endcase
    end
  end

  // strobes act on the same edge as the write
  assign crc_clr_o   = wr_en && (wb_adr_i == REG_SM_CTRL) && wb_dat_i[CTRL_CRC_CLR];
  assign prog_n_wr_o = wr_en && (wb_adr_i == REG_SM_OREGS) && !wb_dat_i[OREGS_PROG_N];

  always_comb begin
    status_word = '0;
    status_word[STATUS_INIT_N]  = sync_init_n_i;
    status_word[STATUS_DONE]    = sync_done_i;
    status_word[STATUS_BUSY]    = sync_busy_i;
    status_word[STATUS_SM_BUSY] = sm_busy_i;
    status_word[STATUS_CRC_ERR] = crc_err_i;
  end

  always_comb begin
    oregs_word = '0;
    oregs_word[OREGS_PROG_N]   = prog_n_o;
    oregs_word[OREGS_INIT_N_O] = init_n_o;
    oregs_word[OREGS_RDWR_N]   = rdwr_n_o;
  end

  // crc_clr is not stored, so it reads back as 0
  always_comb begin
    ctrl_word = '0;
    ctrl_word[CTRL_INIT_N_OEN] = init_n_oen_o;
  end

  always_comb begin
    case (wb_adr_i)
      REG_SM_STATUS: wb_dat_o = status_word;
      REG_SM_OREGS:  wb_dat_o = oregs_word;
      REG_SM_DATA:   wb_dat_o = count_byte_i;
      REG_SM_CTRL:   wb_dat_o = ctrl_word;
      default:       wb_dat_o = '0;
    endcase
  end

  // a master holding stb through the ack must not see a second ack
  a_single_ack: assert property (
    @(posedge epb_clk) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

`default_nettype wire

//--- logic/sm_data_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module sm_data_strobe
  import sm_cfg_pkg::*;
(
  input  wire      epb_clk,
  input  wire      wb_rst_i,
  input  wire      sm_cs_n_i,
  input  sm_byte_t sm_data_i,
  input  wire      prog_n_i,
  input  wire      prog_n_wr_i,
  output sm_byte_t v5c_d_o,
  output logic     v5c_cs_n_o,
  output sm_byte_t count_byte_o
);

  logic      cs_n_smp;
  logic      cs_n_prev;
  sm_byte_t  data_smp;
  logic      sm_strb;
  sm_count_t byte_count;

  // sample cs and data together so the byte matches the low sample
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      cs_n_smp  <= 1'b1;
      cs_n_prev <= 1'b1;
    end else begin
      cs_n_smp  <= sm_cs_n_i;
      cs_n_prev <= cs_n_smp;
    end
  end

  always_ff @(posedge epb_clk) begin
    data_smp <= sm_data_i;
  end

  assign sm_strb = cs_n_prev & ~cs_n_smp;

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      v5c_cs_n_o <= 1'b1;
    end else begin
      v5c_cs_n_o <= ~sm_strb;
    end
  end

  always_ff @(posedge epb_clk) begin
    if (sm_strb) begin
      v5c_d_o <= data_smp;
    end
  end

  // count restarts with each PROGRAM_B cycle of the target
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i || prog_n_wr_i || !prog_n_i) begin
      byte_count <= '0;
    end else if (sm_strb) begin
      byte_count <= byte_count + 1'b1;
    end
  end

  assign count_byte_o = byte_count[SM_BYTE_W-1:0];

  // each host byte gives exactly one target chip-select cycle
  a_cs_pulse: assert property (
    @(posedge epb_clk) disable iff (wb_rst_i)
    !v5c_cs_n_o |=> v5c_cs_n_o
  );

endmodule

`default_nettype wire

//--- logic/sm_pin_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module sm_pin_monitor (
  input  wire  epb_clk,
  input  wire  wb_rst_i,
  input  wire  v5c_done_i,
  input  wire  v5c_busy_i,
  input  wire  v5c_init_n_i,
  input  wire  prog_n_i,
  input  wire  crc_clr_i,
  output logic sync_done_o,
  output logic sync_busy_o,
  output logic sync_init_n_o,
  output logic crc_err_o
);

  logic done_meta;
  logic busy_meta;
  logic init_n_meta;
  logic init_n_prev;
  logic init_n_fall;

  // two-flop synchronizers, init_n idles high
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      done_meta     <= 1'b0;
      busy_meta     <= 1'b0;
      init_n_meta   <= 1'b1;
      sync_done_o   <= 1'b0;
      sync_busy_o   <= 1'b0;
      sync_init_n_o <= 1'b1;
    end else begin
      done_meta     <= v5c_done_i;
      busy_meta     <= v5c_busy_i;
      init_n_meta   <= v5c_init_n_i;
      sync_done_o   <= done_meta;
      sync_busy_o   <= busy_meta;
      sync_init_n_o <= init_n_meta;
    end
  end

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      init_n_prev <= 1'b1;
    end else begin
      init_n_prev <= sync_init_n_o;
    end
  end

  assign init_n_fall = init_n_prev & ~sync_init_n_o;

  // INIT_B pulled low after configuration started means a CRC error
  // clear has priority over a new set
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      crc_err_o <= 1'b0;
    end else if (crc_clr_i) begin
      crc_err_o <= 1'b0;
    end else if (init_n_fall && prog_n_i) begin
      crc_err_o <= 1'b1;
    end
  end

  a_crc_clr: assert property (
    @(posedge epb_clk) disable iff (wb_rst_i)
    crc_clr_i |=> !crc_err_o
  );

endmodule

`default_nettype wire

//--- logic/v5c_sm_top.sv
`timescale 1ns/1ps
`default_nettype none

module v5c_sm_top
  import sm_cfg_pkg::*;
(
  input  wire      epb_clk,
  input  wire      wb_rst_i,
  input  wire      wb_cyc_i,
  input  wire      wb_stb_i,
  input  wire      wb_we_i,
  input  sm_addr_t wb_adr_i,
  input  sm_byte_t wb_dat_i,
  output sm_byte_t wb_dat_o,
  output logic     wb_ack_o,
  input  wire      sm_cs_n_i,
  input  sm_byte_t sm_data_i,
  input  wire      sm_busy_i,
  input  wire      v5c_done_i,
  input  wire      v5c_busy_i,
  input  wire      v5c_init_n_i,
  output sm_byte_t v5c_d_o,
  output logic     v5c_cs_n_o,
  output logic     v5c_rdwr_n_o,
  output logic     v5c_prog_n_o,
  output logic     v5c_init_n_o,
  output logic     v5c_init_n_oen_o,
  output sm_mode_t v5c_mode_o
);

  logic     sync_done;
  logic     sync_busy;
  logic     sync_init_n;
  logic     crc_err;
  logic     crc_clr;
  logic     prog_n_wr;
  sm_byte_t count_byte;

  assign v5c_mode_o = SM_MODE_SLAVE_SELECTMAP;

  sm_ctrl_regs u_regs (
    .epb_clk       (epb_clk),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .sm_busy_i     (sm_busy_i),
    .sync_init_n_i (sync_init_n),
    .sync_done_i   (sync_done),
    .sync_busy_i   (sync_busy),
    .crc_err_i     (crc_err),
    .count_byte_i  (count_byte),
    .prog_n_o      (v5c_prog_n_o),
    .rdwr_n_o      (v5c_rdwr_n_o),
    .init_n_o      (v5c_init_n_o),
    .init_n_oen_o  (v5c_init_n_oen_o),
    .crc_clr_o     (crc_clr),
    .prog_n_wr_o   (prog_n_wr)
  );

  sm_data_strobe u_strobe (
    .epb_clk      (epb_clk),
    .wb_rst_i     (wb_rst_i),
    .sm_cs_n_i    (sm_cs_n_i),
    .sm_data_i    (sm_data_i),
    .prog_n_i     (v5c_prog_n_o),
    .prog_n_wr_i  (prog_n_wr),
    .v5c_d_o      (v5c_d_o),
    .v5c_cs_n_o   (v5c_cs_n_o),
    .count_byte_o (count_byte)
  );

  sm_pin_monitor u_mon (
    .epb_clk       (epb_clk),
    .wb_rst_i      (wb_rst_i),
    .v5c_done_i    (v5c_done_i),
    .v5c_busy_i    (v5c_busy_i),
    .v5c_init_n_i  (v5c_init_n_i),
    .prog_n_i      (v5c_prog_n_o),
    .crc_clr_i     (crc_clr),
    .sync_done_o   (sync_done),
    .sync_busy_o   (sync_busy),
    .sync_init_n_o (sync_init_n),
    .crc_err_o     (crc_err)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module sm_tb -o sm_tb_sim
./obj_dir/sm_tb_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- src.f
logic/sm_cfg_pkg.sv
logic/sm_pin_monitor.sv
logic/sm_data_strobe.sv
logic/sm_ctrl_regs.sv
logic/v5c_sm_top.sv
tests/sm_tb.sv

//--- tests/sm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sm_tb
  import sm_cfg_pkg::*;
();

  localparam int N_TESTS     = 6;
  localparam int N_STROBE    = 20;
  localparam int N_PRE_CLEAR = 3;
  localparam int ACK_LIMIT   = 8;
  // 40 cycles per test and 20 per config byte, plus margin
  localparam int WATCHDOG_CYCLES = N_TESTS * 40 + (N_STROBE + N_PRE_CLEAR) * 20 + 200;

  logic     epb_clk;
  logic     wb_rst_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  sm_addr_t wb_adr_i;
  sm_byte_t wb_dat_i;
  sm_byte_t wb_dat_o;
  logic     wb_ack_o;
  logic     sm_cs_n_i;
  sm_byte_t sm_data_i;
  logic     sm_busy_i;
  logic     v5c_done_i;
  logic     v5c_busy_i;
  logic     v5c_init_n_i;
  sm_byte_t v5c_d_o;
  logic     v5c_cs_n_o;
  logic     v5c_rdwr_n_o;
  logic     v5c_prog_n_o;
  logic     v5c_init_n_o;
  logic     v5c_init_n_oen_o;
  sm_mode_t v5c_mode_o;
  int       errors = 0;
  int       checks = 0;

  v5c_sm_top dut (.*);

  initial begin
    epb_clk = 1'b0;
    forever #50 epb_clk = ~epb_clk;
  end

  // inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge epb_clk);
    #10;
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  task automatic check_byte(input string name, input sm_byte_t got, input sm_byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mode(input string name, input sm_mode_t got, input sm_mode_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic sm_byte_t expect_status(input logic init_n, input logic done,
                                             input logic busy, input logic sm_busy,
                                             input logic crc_err);
    sm_byte_t s;
    s = '0;
    s[STATUS_INIT_N]  = init_n;
    s[STATUS_DONE]    = done;
    s[STATUS_BUSY]    = busy;
    s[STATUS_SM_BUSY] = sm_busy;
    s[STATUS_CRC_ERR] = crc_err;
    return s;
  endfunction

  // one wishbone transfer with the master stalled one edge past the ack
  // the stalled master must not see a second ack
  task automatic bus_transfer(input logic we, input sm_addr_t adr, input sm_byte_t wdat,
                              output sm_byte_t rdat);
    int waited;
    waited = 0;
    rdat = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    next_cycle();
    while (!wb_ack_o && waited < ACK_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (wb_ack_o) begin
      rdat = wb_dat_o;
    end else begin
      report_error($sformatf("no ack for transfer to address %0d", adr));
    end
    next_cycle();
    if (wb_ack_o) begin
      report_error($sformatf("second ack for one transfer to address %0d", adr));
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input sm_addr_t adr, input sm_byte_t dat);
    sm_byte_t discard;
    bus_transfer(1'b1, adr, dat, discard);
  endtask

  task automatic wb_read(input sm_addr_t adr, output sm_byte_t dat);
    bus_transfer(1'b0, adr, 8'h00, dat);
  endtask

  task automatic read_expect(input sm_addr_t adr, input string name, input sm_byte_t exp);
    sm_byte_t got;
    wb_read(adr, got);
    check_byte(name, got, exp);
  endtask

  task automatic status_now(output sm_byte_t s);
    wb_adr_i = REG_SM_STATUS;
    #1;
    s = wb_dat_o;
  endtask

  // target cs pulse is expected on the second edge after sm_cs_n falls
  task automatic cfg_byte(input sm_byte_t b);
    sm_cs_n_i = 1'b0;
    sm_data_i = b;
    next_cycle();
    check_bit("v5c_cs_n_o", v5c_cs_n_o, 1'b1);
    sm_cs_n_i = 1'b1;
    sm_data_i = ~b;
    next_cycle();
    check_bit("v5c_cs_n_o", v5c_cs_n_o, 1'b0);
    check_byte("v5c_d_o", v5c_d_o, b);
    next_cycle();
    check_bit("v5c_cs_n_o", v5c_cs_n_o, 1'b1);
  endtask

  task automatic reset_values();
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    check_bit("v5c_cs_n_o", v5c_cs_n_o, 1'b1);
    check_bit("v5c_prog_n_o", v5c_prog_n_o, 1'b1);
    check_bit("v5c_rdwr_n_o", v5c_rdwr_n_o, 1'b0);
    check_bit("v5c_init_n_o", v5c_init_n_o, 1'b1);
    check_bit("v5c_init_n_oen_o", v5c_init_n_oen_o, 1'b1);
    check_mode("v5c_mode_o", v5c_mode_o, 3'b110);
    read_expect(REG_SM_STATUS, "status", expect_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    read_expect(REG_SM_DATA, "data", 8'h00);
  endtask

  task automatic register_readback();
    sm_byte_t val;
    repeat (6) begin
      val = sm_byte_t'($urandom);
      wb_write(REG_SM_OREGS, val);
      check_bit("v5c_prog_n_o", v5c_prog_n_o, val[OREGS_PROG_N]);
      check_bit("v5c_init_n_o", v5c_init_n_o, val[OREGS_INIT_N_O]);
      check_bit("v5c_rdwr_n_o", v5c_rdwr_n_o, val[OREGS_RDWR_N]);
      read_expect(REG_SM_OREGS, "oregs", val & 8'h07);
      val = sm_byte_t'($urandom);
      wb_write(REG_SM_CTRL, val);
      check_bit("v5c_init_n_oen_o", v5c_init_n_oen_o, val[CTRL_INIT_N_OEN]);
      read_expect(REG_SM_CTRL, "ctrl", val & 8'h01);
    end
    wb_write(REG_SM_OREGS, 8'h03);
    wb_write(REG_SM_CTRL, 8'h01);
  endtask

  task automatic config_strobe();
    // a PROGRAM_B pulse restarts the count
    wb_write(REG_SM_OREGS, 8'h02);
    wb_write(REG_SM_OREGS, 8'h03);
    for (int i = 0; i < N_STROBE; i++) begin
      cfg_byte(sm_byte_t'($urandom));
    end
    read_expect(REG_SM_DATA, "data", sm_byte_t'(N_STROBE % 256));
  endtask

  task automatic count_clear();
    for (int i = 0; i < N_PRE_CLEAR; i++) begin
      cfg_byte(sm_byte_t'($urandom));
    end
    read_expect(REG_SM_DATA, "data", sm_byte_t'((N_STROBE + N_PRE_CLEAR) % 256));
    wb_write(REG_SM_OREGS, 8'h06);
    read_expect(REG_SM_DATA, "data", 8'h00);
    wb_write(REG_SM_OREGS, 8'h03);
    read_expect(REG_SM_DATA, "data", 8'h00);
  endtask

  task automatic status_sync();
    sm_byte_t s;
    v5c_done_i = 1'b1;
    v5c_busy_i = 1'b1;
    sm_busy_i  = 1'b1;
    next_cycle();
    status_now(s);
    check_bit("status.done", s[STATUS_DONE], 1'b0);
    check_bit("status.busy", s[STATUS_BUSY], 1'b0);
    next_cycle();
    status_now(s);
    check_byte("status", s, expect_status(1'b1, 1'b1, 1'b1, 1'b1, 1'b0));
    v5c_done_i = 1'b0;
    v5c_busy_i = 1'b0;
    sm_busy_i  = 1'b0;
    repeat (2) next_cycle();
    status_now(s);
    check_byte("status", s, expect_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  // INIT_B low with PROGRAM_B high flags a CRC error
  task automatic crc_flag();
    v5c_init_n_i = 1'b0;
    repeat (4) next_cycle();
    read_expect(REG_SM_STATUS, "status", expect_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    v5c_init_n_i = 1'b1;
    repeat (4) next_cycle();
    read_expect(REG_SM_STATUS, "status", expect_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    wb_write(REG_SM_CTRL, 8'h03);
    read_expect(REG_SM_STATUS, "status", expect_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    wb_write(REG_SM_OREGS, 8'h02);
    v5c_init_n_i = 1'b0;
    repeat (4) next_cycle();
    read_expect(REG_SM_STATUS, "status", expect_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    v5c_init_n_i = 1'b1;
    wb_write(REG_SM_OREGS, 8'h03);
    repeat (4) next_cycle();
    read_expect(REG_SM_STATUS, "status", expect_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  initial begin
    int seed;
    wb_rst_i     = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = REG_SM_STATUS;
    wb_dat_i     = 8'h00;
    sm_cs_n_i    = 1'b1;
    sm_data_i    = 8'h00;
    sm_busy_i    = 1'b0;
    v5c_done_i   = 1'b0;
    v5c_busy_i   = 1'b0;
    v5c_init_n_i = 1'b1;
    seed = $urandom(32'h5c5abcb6);
    repeat (2) @(posedge epb_clk);
    #10;
    wb_rst_i = 1'b0;
    reset_values();
    register_readback();
    config_strobe();
    count_clear();
    status_sync();
    crc_flag();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge epb_clk);
    $display("timeout: tests still running after %0d cycles, errors: %0d",
             WATCHDOG_CYCLES, errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
